// File: all.f
+incdir+verilog
verilog/cu_pkg.sv
verilog/cu_ifs.sv
verilog/redirect_unit.sv
verilog/hazard_unit.sv
verilog/pipeline_sequencer.sv
verilog/control_unit.sv
bench/control_unit_tb.sv

// File: Makefile
# Verilator build and run for the control unit testbench

BIN  := obj_dir/Vcontrol_unit_tb
SRCS := all.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -f all.f --top-module control_unit_tb -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: bench/control_unit_tb.sv
// control unit testbench
// directed tests for stalls, flushes, redirects and commit controls

`timescale 1ns/1ns
`include "cu_settings.svh"

module control_unit_tb;

    localparam int WAIT_LIMIT = 8;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  id_valid_i, id_is_branch_i, id_predicted_branch_i;
    logic                  id_valid_jal_i, id_csr_fence_i;
    logic [`CU_NUM_IQ-1:0] iq_full_i;
    logic                  free_list_empty_i, out_of_checkpoints_i, gl_full_i, exe_stall_i;
    logic                  wb_valid_i, wb_branch_ok_i;
    cu_pkg::gl_index_t     wb_gl_index_i;
    logic                  commit_valid_i, commit_xcpt_i, commit_ecall_i;
    logic                  commit_csr_fence_i, commit_fence_i, commit_fencei_i, commit_stall_i;
    logic                  csr_eret_i, csr_exception_i, csr_stall_i;
    logic                  miss_icache_i, ready_icache_i;
    cu_pkg::next_pc_sel_e  next_pc_sel_o;
    cu_pkg::fetch_sel_e    fetch_sel_o;
    logic                  stall_if1_o, stall_if2_o, stall_id_o;
    logic                  stall_iq_o, stall_ir_o, stall_rr_o, stall_exe_o;
    logic                  flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o;
    logic                  kill_exe_o;
    logic                  invalidate_icache_o, invalidate_buffer_o;
    logic                  flush_gl_o, flush_gl_commit_o, enable_commit_o;
    cu_pkg::gl_index_t     flush_gl_index_o;

    int     checks;
    int     errors;
    integer seed;

    control_unit uut (.*);

    always #10 clk_i = ~clk_i;

    task set_idle();
        id_valid_i            = 1'b0;
        id_is_branch_i        = 1'b0;
        id_predicted_branch_i = 1'b0;
        id_valid_jal_i        = 1'b0;
        id_csr_fence_i        = 1'b0;
        iq_full_i             = '0;
        free_list_empty_i     = 1'b0;
        out_of_checkpoints_i  = 1'b0;
        gl_full_i             = 1'b0;
        exe_stall_i           = 1'b0;
        wb_valid_i            = 1'b0;
        wb_branch_ok_i        = 1'b1;
        wb_gl_index_i         = '0;
        commit_valid_i        = 1'b0;
        commit_xcpt_i         = 1'b0;
        commit_ecall_i        = 1'b0;
        commit_csr_fence_i    = 1'b0;
        commit_fence_i        = 1'b0;
        commit_fencei_i       = 1'b0;
        commit_stall_i        = 1'b0;
        csr_eret_i            = 1'b0;
        csr_exception_i       = 1'b0;
        csr_stall_i           = 1'b0;
        miss_icache_i         = 1'b0;
        // a ready icache keeps if1 moving
        ready_icache_i        = 1'b1;
    endtask

    task check_bit(input logic got, input logic exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_sel(input logic [1:0] got, input logic [1:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task check_index(input cu_pkg::gl_index_t got, input cu_pkg::gl_index_t exp,
                     input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // order is if1 if2 id iq ir rr exe
    task check_stalls(input logic [6:0] exp, input string what);
        logic [6:0] got;
        got = {stall_if1_o, stall_if2_o, stall_id_o, stall_iq_o,
               stall_ir_o, stall_rr_o, stall_exe_o};
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s stalls %b, expected %b", $time, what, got, exp);
        end
    endtask

    // order is if id ir rr exe kill_exe
    task check_flushes(input logic [5:0] exp, input string what);
        logic [5:0] got;
        got = {flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o, kill_exe_o};
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s flushes %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_latency(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s after %0d cycles, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task test_reset_idle();
        logic [31:0] rnd;
        int          n;
        @(negedge clk_i);
        set_idle();
        #1;
        check_flushes(6'b000000, "idle");
        check_stalls(7'b0000000, "idle");
        check_bit(invalidate_icache_o, 1'b0, "idle invalidate_icache");
        check_bit(invalidate_buffer_o, 1'b0, "idle invalidate_buffer");
        check_bit(flush_gl_o, 1'b0, "idle flush_gl");
        check_bit(flush_gl_commit_o, 1'b0, "idle flush_gl_commit");
        check_bit(enable_commit_o, 1'b1, "idle enable_commit");
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_BP_OR_PC4, "idle next_pc_sel");
        check_sel(fetch_sel_o, cu_pkg::SEL_DECODE, "idle fetch_sel");
        // the gl index only leaks out on a mispredict
        for (n = 0; n < 4; n++) begin
            @(negedge clk_i);
            rnd = $random(seed);
            wb_gl_index_i  = rnd[`CU_GL_IDX_W-1:0];
            wb_branch_ok_i = rnd[31];
            #1;
            check_index(flush_gl_index_o, '0, "idle flush_gl_index");
            check_flushes(6'b000000, "idle sweep");
        end
    endtask

    task test_stall_priority();
        @(negedge clk_i);
        set_idle();
        csr_stall_i = 1'b1;
        #1;
        check_stalls(7'b1111111, "csr_stall");
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_KEEP, "csr_stall next_pc_sel");
        @(negedge clk_i);
        exe_stall_i = 1'b1;
        #1;
        check_stalls(7'b1111111, "csr_stall over exe_stall");
        @(negedge clk_i);
        set_idle();
        exe_stall_i = 1'b1;
        #1;
        check_stalls(7'b0001110, "exe_stall");
        @(negedge clk_i);
        set_idle();
        iq_full_i = 1;
        #1;
        check_stalls(7'b1110000, "issue queue full");
        @(negedge clk_i);
        set_idle();
        gl_full_i = 1'b1;
        #1;
        check_stalls(7'b0001110, "gl_full");
        check_flushes(6'b000100, "gl_full bubble");
        @(negedge clk_i);
        set_idle();
        free_list_empty_i = 1'b1;
        #1;
        check_stalls(7'b0001000, "free_list_empty");
        @(negedge clk_i);
        set_idle();
        miss_icache_i = 1'b1;
        #1;
        check_stalls(7'b1000000, "icache miss");
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_KEEP, "icache miss next_pc_sel");
        @(negedge clk_i);
        set_idle();
    endtask

    task test_mispredict();
        logic [31:0]       rnd;
        cu_pkg::gl_index_t idx;
        int                n;
        for (n = 0; n < 3; n++) begin
            @(negedge clk_i);
            set_idle();
            rnd = $random(seed);
            idx = rnd[`CU_GL_IDX_W-1:0];
            wb_valid_i     = 1'b1;
            wb_branch_ok_i = 1'b0;
            wb_gl_index_i  = idx;
            #1;
            check_flushes(6'b111101, "mispredict");
            check_sel(fetch_sel_o, cu_pkg::SEL_EXECUTION, "mispredict fetch_sel");
            check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_JUMP, "mispredict next_pc_sel");
            check_bit(flush_gl_o, 1'b1, "mispredict flush_gl");
            check_index(flush_gl_index_o, idx, "mispredict flush_gl_index");
        end
        @(negedge clk_i);
        set_idle();
    endtask

    task test_commit_exception();
        int cycles;
        @(negedge clk_i);
        set_idle();
        commit_valid_i = 1'b1;
        commit_xcpt_i  = 1'b1;
        #1;
        check_bit(enable_commit_o, 1'b0, "exception cycle enable_commit");
        check_bit(flush_gl_commit_o, 1'b0, "exception cycle flush_gl_commit");
        @(negedge clk_i);
        set_idle();
        #1;
        cycles = 1;
        while (!flush_gl_commit_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (!flush_gl_commit_o) begin
            errors++;
            $display("Timeout at %0t ns: the exception redirect never arrived", $time);
        end else begin
            check_latency(cycles, 1, "exception redirect");
        end
        check_bit(invalidate_buffer_o, 1'b1, "exception invalidate_buffer");
        check_flushes(6'b111110, "exception");
        check_sel(fetch_sel_o, cu_pkg::SEL_CSR, "exception fetch_sel");
        @(negedge clk_i);
        #1;
        check_bit(flush_gl_commit_o, 1'b0, "after exception flush_gl_commit");
        check_bit(invalidate_buffer_o, 1'b0, "after exception invalidate_buffer");
        check_flushes(6'b000000, "after exception");
        check_sel(fetch_sel_o, cu_pkg::SEL_DECODE, "after exception fetch_sel");
    endtask

    task test_csr_fence();
        int cycles;
        @(negedge clk_i);
        set_idle();
        id_valid_i     = 1'b1;
        id_csr_fence_i = 1'b1;
        #1;
        check_flushes(6'b100000, "decode csr fence");
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_KEEP, "decode csr fence next_pc_sel");
        @(negedge clk_i);
        set_idle();
        #1;
        // the fence is still in flight
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_KEEP, "fence in flight next_pc_sel");
        @(negedge clk_i);
        commit_valid_i     = 1'b1;
        commit_csr_fence_i = 1'b1;
        #1;
        check_stalls(7'b1000000, "commit csr fence");
        check_bit(invalidate_buffer_o, 1'b1, "commit csr fence invalidate_buffer");
        @(negedge clk_i);
        set_idle();
        #1;
        cycles = 1;
        while (fetch_sel_o !== cu_pkg::SEL_CSR_RW && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (fetch_sel_o !== cu_pkg::SEL_CSR_RW) begin
            errors++;
            $display("Timeout at %0t ns: the CSR fence redirect never arrived", $time);
        end else begin
            check_latency(cycles, 1, "csr fence redirect");
        end
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_JUMP, "csr redirect next_pc_sel");
        @(negedge clk_i);
        #1;
        check_sel(next_pc_sel_o, cu_pkg::NEXT_PC_BP_OR_PC4, "fence retired next_pc_sel");
        check_sel(fetch_sel_o, cu_pkg::SEL_DECODE, "fence retired fetch_sel");
        @(negedge clk_i);
        commit_valid_i  = 1'b1;
        commit_fencei_i = 1'b1;
        #1;
        check_bit(invalidate_icache_o, 1'b1, "fence.i invalidate_icache");
        @(negedge clk_i);
        set_idle();
        #1;
        check_bit(invalidate_icache_o, 1'b0, "after fence.i invalidate_icache");
    endtask

    initial begin
        int n;
        checks = 0;
        errors = 0;
        seed   = 32'hdfe401c3;
        clk_i  = 1'b0;
        rstn_i = 1'b0;
        set_idle();
        for (n = 0; n < 8; n++) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        rstn_i = 1'b1;

        test_reset_idle();
        test_stall_priority();
        test_mispredict();
        test_commit_exception();
        test_csr_fence();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/control_unit.sv
// control unit top level
// turns pipeline stage status into stall, flush and redirect controls

`timescale 1ns/1ns
`include "cu_settings.svh"

module control_unit (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  id_valid_i,
    input  logic                  id_is_branch_i,
    input  logic                  id_predicted_branch_i,
    input  logic                  id_valid_jal_i,
    input  logic                  id_csr_fence_i,
    input  logic [`CU_NUM_IQ-1:0] iq_full_i,
    input  logic                  free_list_empty_i,
    input  logic                  out_of_checkpoints_i,
    input  logic                  gl_full_i,
    input  logic                  exe_stall_i,
    input  logic                  wb_valid_i,
    input  logic                  wb_branch_ok_i,
    input  cu_pkg::gl_index_t     wb_gl_index_i,
    input  logic                  commit_valid_i,
    input  logic                  commit_xcpt_i,
    input  logic                  commit_ecall_i,
    input  logic                  commit_csr_fence_i,
    input  logic                  commit_fence_i,
    input  logic                  commit_fencei_i,
    input  logic                  commit_stall_i,
    input  logic                  csr_eret_i,
    input  logic                  csr_exception_i,
    input  logic                  csr_stall_i,
    input  logic                  miss_icache_i,
    input  logic                  ready_icache_i,
    output cu_pkg::next_pc_sel_e  next_pc_sel_o,
    output cu_pkg::fetch_sel_e    fetch_sel_o,
    output logic                  stall_if1_o,
    output logic                  stall_if2_o,
    output logic                  stall_id_o,
    output logic                  stall_iq_o,
    output logic                  stall_ir_o,
    output logic                  stall_rr_o,
    output logic                  stall_exe_o,
    output logic                  flush_if_o,
    output logic                  flush_id_o,
    output logic                  flush_ir_o,
    output logic                  flush_rr_o,
    output logic                  flush_exe_o,
    output logic                  kill_exe_o,
    output logic                  invalidate_icache_o,
    output logic                  invalidate_buffer_o,
    output logic                  flush_gl_o,
    output cu_pkg::gl_index_t     flush_gl_index_o,
    output logic                  flush_gl_commit_o,
    output logic                  enable_commit_o
);
    redirect_if redir (.clk_i(clk_i), .rstn_i(rstn_i));
    hazard_if   haz   (.clk_i(clk_i), .rstn_i(rstn_i));

    redirect_unit u_redirect (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .id_valid_i            (id_valid_i),
        .id_is_branch_i        (id_is_branch_i),
        .id_predicted_branch_i (id_predicted_branch_i),
        .id_valid_jal_i        (id_valid_jal_i),
        .id_csr_fence_i        (id_csr_fence_i),
        .wb_valid_i            (wb_valid_i),
        .wb_branch_ok_i        (wb_branch_ok_i),
        .wb_gl_index_i         (wb_gl_index_i),
        .commit_valid_i        (commit_valid_i),
        .commit_xcpt_i         (commit_xcpt_i),
        .commit_ecall_i        (commit_ecall_i),
        .commit_csr_fence_i    (commit_csr_fence_i),
        .commit_fence_i        (commit_fence_i),
        .commit_fencei_i       (commit_fencei_i),
        .commit_stall_i        (commit_stall_i),
        .csr_eret_i            (csr_eret_i),
        .csr_exception_i       (csr_exception_i),
        .redir                 (redir.producer),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o),
        .flush_gl_o            (flush_gl_o),
        .flush_gl_commit_o     (flush_gl_commit_o),
        .enable_commit_o       (enable_commit_o),
        .flush_gl_index_o      (flush_gl_index_o)
    );

    hazard_unit u_hazard (
        .iq_full_i            (iq_full_i),
        .free_list_empty_i    (free_list_empty_i),
        .out_of_checkpoints_i (out_of_checkpoints_i),
        .gl_full_i            (gl_full_i),
        .exe_stall_i          (exe_stall_i),
        .miss_icache_i        (miss_icache_i),
        .ready_icache_i       (ready_icache_i),
        .csr_stall_i          (csr_stall_i),
        .commit_valid_i       (commit_valid_i),
        .commit_csr_fence_i   (commit_csr_fence_i),
        .haz                  (haz.producer)
    );

    pipeline_sequencer u_sequencer (
        .redir         (redir.consumer),
        .haz           (haz.consumer),
        .next_pc_sel_o (next_pc_sel_o),
        .fetch_sel_o   (fetch_sel_o),
        .stall_if1_o   (stall_if1_o),
        .stall_if2_o   (stall_if2_o),
        .stall_id_o    (stall_id_o),
        .stall_iq_o    (stall_iq_o),
        .stall_ir_o    (stall_ir_o),
        .stall_rr_o    (stall_rr_o),
        .stall_exe_o   (stall_exe_o),
        .flush_if_o    (flush_if_o),
        .flush_id_o    (flush_id_o),
        .flush_ir_o    (flush_ir_o),
        .flush_rr_o    (flush_rr_o),
        .flush_exe_o   (flush_exe_o),
        .kill_exe_o    (kill_exe_o)
    );

endmodule

// File: verilog/pipeline_sequencer.sv
// pipeline sequencer
// merges redirects and hazards into stage flushes, stalls and the
// next pc and fetch address selections

`timescale 1ns/1ns

module pipeline_sequencer (
    redirect_if.consumer        redir,
    hazard_if.consumer          haz,
    output cu_pkg::next_pc_sel_e next_pc_sel_o,
    output cu_pkg::fetch_sel_e   fetch_sel_o,
    output logic                stall_if1_o,
    output logic                stall_if2_o,
    output logic                stall_id_o,
    output logic                stall_iq_o,
    output logic                stall_ir_o,
    output logic                stall_rr_o,
    output logic                stall_exe_o,
    output logic                flush_if_o,
    output logic                flush_id_o,
    output logic                flush_ir_o,
    output logic                flush_rr_o,
    output logic                flush_exe_o,
    output logic                kill_exe_o
);
    logic hard_redirect;
    logic soft_redirect;

    // redirects that discard everything in the frontend
    assign hard_redirect = redir.exception_q | redir.csr_q | redir.branch_miss;
    // only the fetch stage is refetched, decode keeps its instruction
    assign soft_redirect = redir.fence_pending | redir.decode_redirect | redir.commit_fence;

    always_comb begin
        flush_if_o = 1'b0;
        flush_id_o = 1'b0;
        if (hard_redirect) begin
            flush_if_o = 1'b1;
            flush_id_o = 1'b1;
        end else if (soft_redirect && !haz.csr_hold) begin
            flush_if_o = 1'b1;
        end
    end

    always_comb begin
        flush_ir_o  = 1'b0;
        flush_rr_o  = 1'b0;
        flush_exe_o = 1'b0;
        kill_exe_o  = 1'b0;
        if (redir.exception_q) begin
            flush_ir_o  = 1'b1;
            flush_rr_o  = 1'b1;
            flush_exe_o = 1'b1;
        end else if (redir.branch_miss) begin
            // the mispredicted branch itself still leaves exe
            flush_ir_o = 1'b1;
            flush_rr_o = 1'b1;
            kill_exe_o = 1'b1;
        end else if (haz.rr_bubble) begin
            flush_rr_o = 1'b1;
        end
    end

    always_comb begin
        if (redir.branch_miss || redir.decode_redirect || redir.exception_q || redir.csr_q) begin
            next_pc_sel_o = cu_pkg::NEXT_PC_JUMP;
        end else if (haz.stall_if1 || redir.fence_pending || redir.commit_fence) begin
            next_pc_sel_o = cu_pkg::NEXT_PC_KEEP;
        end else begin
            next_pc_sel_o = cu_pkg::NEXT_PC_BP_OR_PC4;
        end
    end

    always_comb begin
        if (redir.exception_q) begin
            fetch_sel_o = cu_pkg::SEL_CSR;
        end else if (redir.csr_q) begin
            fetch_sel_o = cu_pkg::SEL_CSR_RW;
        end else if (redir.branch_miss) begin
            fetch_sel_o = cu_pkg::SEL_EXECUTION;
        end else begin
            fetch_sel_o = cu_pkg::SEL_DECODE;
        end
    end

    assign stall_if1_o = haz.stall_if1;
    assign stall_if2_o = haz.stall_if2;
    assign stall_id_o  = haz.stall_id;
    assign stall_iq_o  = haz.stall_iq;
    assign stall_ir_o  = haz.stall_ir;
    assign stall_rr_o  = haz.stall_rr;
    assign stall_exe_o = haz.stall_exe;

    a_id_flush_with_if: assert property (
        @(posedge redir.clk_i) disable iff (!redir.rstn_i) flush_id_o |-> flush_if_o
    );

endmodule

// File: verilog/hazard_unit.sv
// hazard unit
// frontend and backend stall priorities and the rename register bubble

`timescale 1ns/1ns
`include "cu_settings.svh"

module hazard_unit (
    input  logic [`CU_NUM_IQ-1:0] iq_full_i,
    input  logic                  free_list_empty_i,
    input  logic                  out_of_checkpoints_i,
    input  logic                  gl_full_i,
    input  logic                  exe_stall_i,
    input  logic                  miss_icache_i,
    input  logic                  ready_icache_i,
    input  logic                  csr_stall_i,
    input  logic                  commit_valid_i,
    input  logic                  commit_csr_fence_i,
    hazard_if.producer            haz
);
    logic fetch_only_stall;

    // only the first fetch stage waits on the icache or a committing csr fence
    assign fetch_only_stall = (commit_valid_i & commit_csr_fence_i) |
                              miss_icache_i | ~ready_icache_i;

    always_comb begin
        haz.stall_if1 = 1'b0;
        haz.stall_if2 = 1'b0;
        haz.stall_id  = 1'b0;
        if (csr_stall_i || (|iq_full_i)) begin
            haz.stall_if1 = 1'b1;
            haz.stall_if2 = 1'b1;
            haz.stall_id  = 1'b1;
        end else if (fetch_only_stall) begin
            haz.stall_if1 = 1'b1;
        end
    end

    always_comb begin
        haz.stall_iq  = 1'b0;
        haz.stall_ir  = 1'b0;
        haz.stall_rr  = 1'b0;
        haz.stall_exe = 1'b0;
        if (csr_stall_i) begin
            haz.stall_iq  = 1'b1;
            haz.stall_ir  = 1'b1;
            haz.stall_rr  = 1'b1;
            haz.stall_exe = 1'b1;
        end else if (exe_stall_i || gl_full_i) begin
            haz.stall_iq = 1'b1;
            haz.stall_ir = 1'b1;
            haz.stall_rr = 1'b1;
        end else if (free_list_empty_i || out_of_checkpoints_i) begin
            haz.stall_iq = 1'b1;
        end
    end

    // bubble into rr while the gl is full and exe keeps moving
    assign haz.rr_bubble = gl_full_i & ~exe_stall_i;
    assign haz.csr_hold  = csr_stall_i;

    a_if2_needs_if1: assert property (
        @(posedge haz.clk_i) disable iff (!haz.rstn_i) haz.stall_if2 |-> haz.stall_if1
    );

endmodule

// File: verilog/redirect_unit.sv
// redirect unit
// registers exception and CSR fence redirects for one cycle, tracks a CSR
// fence in flight, and drives invalidation, GL flush and commit controls

`timescale 1ns/1ns

module redirect_unit (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              id_valid_i,
    input  logic              id_is_branch_i,
    input  logic              id_predicted_branch_i,
    input  logic              id_valid_jal_i,
    input  logic              id_csr_fence_i,
    input  logic              wb_valid_i,
    input  logic              wb_branch_ok_i,
    input  cu_pkg::gl_index_t wb_gl_index_i,
    input  logic              commit_valid_i,
    input  logic              commit_xcpt_i,
    input  logic              commit_ecall_i,
    input  logic              commit_csr_fence_i,
    input  logic              commit_fence_i,
    input  logic              commit_fencei_i,
    input  logic              commit_stall_i,
    input  logic              csr_eret_i,
    input  logic              csr_exception_i,
    redirect_if.producer      redir,
    output logic              invalidate_icache_o,
    output logic              invalidate_buffer_o,
    output logic              flush_gl_o,
    output logic              flush_gl_commit_o,
    output logic              enable_commit_o,
    output cu_pkg::gl_index_t flush_gl_index_o
);
    logic xcpt_event, csr_event;
    logic exception_d, exception_q;
    logic csr_d, csr_q;
    logic fence_tracker_q;
    logic id_fence, commit_csr_fence;

    assign id_fence         = id_valid_i & id_csr_fence_i;
    assign commit_csr_fence = commit_valid_i & commit_csr_fence_i;

    // exception, ecall, eret or csr exception seen at commit
    assign xcpt_event = (commit_valid_i & (commit_xcpt_i | commit_ecall_i)) |
                        csr_eret_i | csr_exception_i;
    assign csr_event  = commit_csr_fence & ~xcpt_event;

    // a set state blocks its own next value, so each redirect lasts one cycle
    assign exception_d = ~exception_q & xcpt_event;
    assign csr_d       = ~csr_q & csr_event;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exception_q <= 1'b0;
            csr_q       <= 1'b0;
        end else begin
            exception_q <= exception_d;
            csr_q       <= csr_d;
        end
    end

    // csr fence between decode and commit, clearing has priority
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_tracker_q <= 1'b0;
        end else if (commit_csr_fence || exception_q || redir.branch_miss) begin
            fence_tracker_q <= 1'b0;
        end else if (id_fence) begin
            fence_tracker_q <= 1'b1;
        end
    end

    assign redir.exception_q     = exception_q;
    assign redir.csr_q           = csr_q;
    assign redir.branch_miss     = wb_valid_i & ~wb_branch_ok_i;
    assign redir.decode_redirect = id_valid_jal_i |
                                   (id_valid_i & ~id_is_branch_i & id_predicted_branch_i);
    assign redir.fence_pending   = id_fence | fence_tracker_q | commit_csr_fence;
    assign redir.commit_fence    = commit_valid_i & commit_fence_i;

    // fence.i may follow self modifying code
    assign invalidate_icache_o = commit_valid_i & commit_fencei_i;
    assign invalidate_buffer_o = exception_q |
        (commit_valid_i & (commit_fencei_i | (commit_csr_fence_i & ~commit_fence_i)));

    assign flush_gl_o       = redir.branch_miss;
    assign flush_gl_index_o = redir.branch_miss ? wb_gl_index_i : '0;

    assign flush_gl_commit_o = exception_q;
    assign enable_commit_o   = ~commit_stall_i & ~xcpt_event;

    // a csr redirect is never raised in the cycle after an exception event
    a_redirect_onehot: assert property (
        @(posedge clk_i) disable iff (!rstn_i) !(exception_q && csr_q)
    );

endmodule

// File: verilog/cu_ifs.sv
// control unit interfaces
// redirect_if carries redirect state from the redirect unit
// hazard_if carries stall levels from the hazard unit

`timescale 1ns/1ns

interface redirect_if (
    input logic clk_i,
    input logic rstn_i
);
    logic exception_q;
    logic csr_q;
    logic branch_miss;
    logic decode_redirect;
    logic fence_pending;
    logic commit_fence;

    modport producer (
        output exception_q, csr_q, branch_miss, decode_redirect, fence_pending, commit_fence
    );

    // clock and reset only serve the checks on the consumer side
    modport consumer (
        input clk_i, rstn_i,
        input exception_q, csr_q, branch_miss, decode_redirect, fence_pending, commit_fence
    );
endinterface

interface hazard_if (
    input logic clk_i,
    input logic rstn_i
);
    logic stall_if1, stall_if2, stall_id;
    logic stall_iq, stall_ir, stall_rr, stall_exe;
    logic csr_hold;
    logic rr_bubble;

    modport producer (
        input clk_i, rstn_i,
        output stall_if1, stall_if2, stall_id, stall_iq, stall_ir, stall_rr, stall_exe,
        output csr_hold, rr_bubble
    );

    modport consumer (
        input stall_if1, stall_if2, stall_id, stall_iq, stall_ir, stall_rr, stall_exe,
        input csr_hold, rr_bubble
    );
endinterface

// File: verilog/cu_pkg.sv
// control unit package
// selector encodings for the fetch stage and the graduation list index type

`include "cu_settings.svh"

package cu_pkg;

    // next pc choice handed to the fetch stage
    typedef enum logic [1:0] {
        NEXT_PC_BP_OR_PC4 = 2'b00,
        NEXT_PC_KEEP      = 2'b01,
        NEXT_PC_JUMP      = 2'b10
    } next_pc_sel_e;

    // where the fetch address comes from on a redirect
    typedef enum logic [1:0] {
        SEL_DECODE    = 2'b00,
        SEL_EXECUTION = 2'b01,
        SEL_CSR       = 2'b10,
        SEL_CSR_RW    = 2'b11
    } fetch_sel_e;

    // graduation list entry index
    typedef logic [`CU_GL_IDX_W-1:0] gl_index_t;

endpackage

// File: verilog/cu_settings.svh
// control unit settings
// width and count macros shared by the package and the RTL

`ifndef CU_SETTINGS_SVH
`define CU_SETTINGS_SVH

// issue queues, each reports its own full flag
`define CU_NUM_IQ 2

// graduation list index width
`define CU_GL_IDX_W 6

`endif
